//--- Makefile
# Verilator build and run of the axi pmu bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_pmu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '** FAIL **' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
rtl/pmu_pkg.sv
rtl/pmu_frame_if.sv
rtl/pmu_spi_link.sv
rtl/pmu_cmd_fifo.sv
rtl/pmu_axi_regs.sv
rtl/pmu_status_store.sv
rtl/axi_pmu.sv
verification/axi_pmu_assert.sv
verification/tb_axi_pmu.sv

//--- rtl/axi_pmu.sv
/* axi pmu bridge top level
   axi4-lite register front end and spi slave link to the pmu controller */
`timescale 1ns/1ps
`default_nettype none

module axi_pmu #(
  parameter int FIFO_DEPTH = 16  // power of two
) (
  input  logic        s_axi_aclk,
  input  logic        s_axi_areset,

  input  logic        ss,
  input  logic        mosi,
  input  logic        sck,
  output logic        miso,

  input  logic [31:0] s_axi_awaddr,
  input  logic        s_axi_awvalid,
  output logic        s_axi_awready,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0]  s_axi_wstrb,
  input  logic        s_axi_wvalid,
  output logic        s_axi_wready,
  output logic [1:0]  s_axi_bresp,
  output logic        s_axi_bvalid,
  input  logic        s_axi_bready,
  input  logic [31:0] s_axi_araddr,
  input  logic        s_axi_arvalid,
  output logic        s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  output logic        s_axi_rvalid,
  input  logic        s_axi_rready,

  output logic        s_axi_irq
);

  logic                      push;
  logic [pmu_pkg::cmd_w-1:0] push_data;
  logic [7:0]                irq_enable;
  pmu_pkg::pmu_status_t      status;

  pmu_frame_if u_frame_if ();

  pmu_spi_link u_spi_link (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_areset (s_axi_areset),
    .ss           (ss),
    .sck          (sck),
    .mosi         (mosi),
    .miso         (miso),
    .frame        (u_frame_if.link)
  );

  pmu_cmd_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_areset (s_axi_areset),
    .push         (push),
    .push_data    (push_data),
    .frame        (u_frame_if.cmd_source)
  );

  pmu_axi_regs u_axi_regs (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_areset  (s_axi_areset),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .status        (status),
    .irq_enable    (irq_enable),
    .push          (push),
    .push_data     (push_data)
  );

  pmu_status_store u_status_store (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_areset (s_axi_areset),
    .frame        (u_frame_if.rx_sink),
    .irq_enable   (irq_enable),
    .status       (status),
    .irq          (s_axi_irq)
  );

endmodule

`default_nettype wire

//--- rtl/pmu_axi_regs.sv
/* pmu axi4-lite front end
   register reads, shutdown and irq-enable writes, command word formatting */
`timescale 1ns/1ps
`default_nettype none

module pmu_axi_regs (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_areset,

  input  logic [31:0]               s_axi_awaddr,
  input  logic                      s_axi_awvalid,
  output logic                      s_axi_awready,

  input  logic [31:0]               s_axi_wdata,
  input  logic [3:0]                s_axi_wstrb,
  input  logic                      s_axi_wvalid,
  output logic                      s_axi_wready,

  output logic [1:0]                s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  logic                      s_axi_bready,

  input  logic [31:0]               s_axi_araddr,
  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,

  output logic [31:0]               s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready,

  input  pmu_pkg::pmu_status_t      status,
  output logic [7:0]                irq_enable,
  output logic                      push,
  output logic [pmu_pkg::cmd_w-1:0] push_data
);

  pmu_pkg::axi_state_e state;
  logic [7:0]          addr;
  logic [31:0]         shutdown;

  logic wr_fire;
  logic is_cmd;

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      state <= pmu_pkg::st_idle;
      addr  <= '0;
    end else begin
      case (state)
        pmu_pkg::st_idle: begin
          if (s_axi_arvalid) begin  // reads win over writes
            state <= pmu_pkg::st_read_resp;
            addr  <= s_axi_araddr[7:0];
          end else if (s_axi_awvalid) begin
            state <= pmu_pkg::st_write_data;
            addr  <= s_axi_awaddr[7:0];
          end
        end
        pmu_pkg::st_read_resp: begin
          if (s_axi_rready) begin
            state <= pmu_pkg::st_idle;
          end
        end
        pmu_pkg::st_write_data: begin
          if (s_axi_wvalid) begin
            state <= pmu_pkg::st_write_resp;
          end
        end
        pmu_pkg::st_write_resp: begin
          if (s_axi_bready) begin
            state <= pmu_pkg::st_idle;
          end
        end
        default: state <= pmu_pkg::st_idle;
      endcase
    end
  end

  assign wr_fire = (state == pmu_pkg::st_write_data) && s_axi_wvalid;

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      shutdown   <= '0;
      irq_enable <= '0;
    end else if (wr_fire) begin
      if (addr == pmu_pkg::reg_shutdown) begin
        shutdown <= s_axi_wdata;
      end
      if (addr == pmu_pkg::reg_irq_ver) begin
        irq_enable <= s_axi_wdata[15:8];
      end
    end
  end

  // shutdown and every address past the irq register go out over spi
  assign is_cmd = (addr == pmu_pkg::reg_shutdown) || (addr > pmu_pkg::reg_irq_ver);
  assign push   = wr_fire && is_cmd;

  always_comb begin
    if (addr == pmu_pkg::reg_shutdown) begin
      push_data = {s_axi_wdata[23:0], 8'h00};
    end else begin
      push_data = {s_axi_wdata[7:0], s_axi_wdata[15:8], addr, 8'h01};
    end
  end

  always_comb begin
    case (addr)
      pmu_pkg::reg_shutdown:    s_axi_rdata = shutdown;
      pmu_pkg::reg_irq_ver:     s_axi_rdata = {16'h0000, irq_enable,
                                               status.version_maj, status.version_min};
      pmu_pkg::reg_battery:     s_axi_rdata = {8'h00, status.battery_voltage,
                                               status.battery_temp_alert, status.battery_online,
                                               status.battery_health, status.battery_status};
      pmu_pkg::reg_charger:     s_axi_rdata = {27'd0, status.charger_charge_type,
                                               status.charger_online, status.charger_health};
      pmu_pkg::reg_gauge_a:     s_axi_rdata = {status.temp, status.charge_acc};
      pmu_pkg::reg_gauge_b:     s_axi_rdata = {8'h00, status.gauge_status, status.voltage};
      pmu_pkg::reg_charge_full: s_axi_rdata = {16'h0000, status.charge_last_full};
      pmu_pkg::reg_settings:    s_axi_rdata = {24'd0, status.settings};
      default:                  s_axi_rdata = pmu_pkg::read_default;
    endcase
  end

  assign s_axi_arready = (state == pmu_pkg::st_idle);
  assign s_axi_awready = (state == pmu_pkg::st_idle);
  assign s_axi_rvalid  = (state == pmu_pkg::st_read_resp);
  assign s_axi_wready  = (state == pmu_pkg::st_write_data);
  assign s_axi_bvalid  = (state == pmu_pkg::st_write_resp);
  assign s_axi_rresp   = 2'b00;  // always okay
  assign s_axi_bresp   = 2'b00;

endmodule

`default_nettype wire

//--- rtl/pmu_cmd_fifo.sv
/* pmu command fifo
   holds host command words until an spi frame carries them out */
`timescale 1ns/1ps
`default_nettype none

module pmu_cmd_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                     s_axi_aclk,
  input  logic                     s_axi_areset,
  input  logic                     push,
  input  logic [pmu_pkg::cmd_w-1:0] push_data,
  pmu_frame_if.cmd_source          frame
);

  localparam int ptr_w = $clog2(DEPTH);

  logic [pmu_pkg::cmd_w-1:0] mem [DEPTH];
  logic [ptr_w-1:0]          wr_ptr;
  logic [ptr_w-1:0]          rd_ptr;
  logic [ptr_w:0]            count;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == (ptr_w + 1)'(DEPTH));
  assign empty = (count == '0);
  assign wr_en = push && !full;              // full drops the command
  assign rd_en = frame.frame_stb && !empty;  // word was sent in the frame just ended

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign frame.cmd_word  = empty ? '0 : mem[rd_ptr];  // idle frames carry zeros
  assign frame.cmd_valid = !empty;

endmodule

`default_nettype wire

//--- rtl/pmu_frame_if.sv
/* pmu frame exchange
   received frame and strobe from the spi link, next command word back to it */
`timescale 1ns/1ps
`default_nettype none

interface pmu_frame_if;

  logic                         frame_stb;  // one clock at the end of a full frame
  logic [pmu_pkg::frame_w-1:0]  rx_frame;
  logic [pmu_pkg::cmd_w-1:0]    cmd_word;
  logic                         cmd_valid;

  modport link (
    output frame_stb,
    output rx_frame,
    input  cmd_word,
    input  cmd_valid
  );

  modport cmd_source (
    output cmd_word,
    output cmd_valid,
    input  frame_stb
  );

  modport rx_sink (
    input frame_stb,
    input rx_frame
  );

endinterface

`default_nettype wire

//--- rtl/pmu_pkg.sv
/* pmu bridge shared definitions
   frame layout, register map, front-end states and decoded status */
`default_nettype none

package pmu_pkg;

  localparam int frame_w = 64;
  localparam int cmd_w   = 32;

  typedef enum logic [7:0] {
    type_battery = 8'd0,
    type_gauge   = 8'd1,
    type_charge  = 8'd2
  } frame_type_e;

  typedef enum logic [1:0] {
    st_idle,
    st_read_resp,
    st_write_data,
    st_write_resp
  } axi_state_e;

  localparam logic [7:0] reg_shutdown    = 8'h00;
  localparam logic [7:0] reg_irq_ver     = 8'h04;
  localparam logic [7:0] reg_battery     = 8'h08;
  localparam logic [7:0] reg_charger     = 8'h0c;
  localparam logic [7:0] reg_gauge_a     = 8'h10;
  localparam logic [7:0] reg_gauge_b     = 8'h14;
  localparam logic [7:0] reg_charge_full = 8'h18;
  localparam logic [7:0] reg_settings    = 8'h1c;

  localparam logic [31:0] read_default = 32'hdead_beef;

  typedef struct packed {
    // battery frame
    logic [15:0] battery_voltage;
    logic [1:0]  battery_temp_alert;
    logic        battery_online;
    logic [2:0]  battery_health;
    logic [1:0]  battery_status;
    logic [1:0]  charger_health;
    logic        charger_online;
    logic [1:0]  charger_charge_type;
    logic [3:0]  version_maj;
    logic [3:0]  version_min;
    // gauge frame
    logic [7:0]  gauge_status;
    logic [15:0] voltage;
    logic [15:0] temp;
    logic [15:0] charge_acc;
    // charge frame
    logic [15:0] charge_last_full;
    logic [7:0]  settings;
  } pmu_status_t;

endpackage

`default_nettype wire

//--- rtl/pmu_spi_link.sv
/* pmu spi link
   spi slave, mode 0, msb first; shifts 64-bit frames in and out
   and strobes once per complete frame */
`timescale 1ns/1ps
`default_nettype none

module pmu_spi_link (
  input  logic      s_axi_aclk,
  input  logic      s_axi_areset,
  input  logic      ss,
  input  logic      sck,
  input  logic      mosi,
  output logic      miso,
  pmu_frame_if.link frame
);

  localparam int cnt_w = $clog2(pmu_pkg::frame_w) + 1;
  localparam int pad_w = pmu_pkg::frame_w - pmu_pkg::cmd_w - 1;
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(pmu_pkg::frame_w);

  logic [2:0] ss_q;   // two sync stages plus edge history
  logic [2:0] sck_q;
  logic [1:0] mosi_q;

  logic ss_active;
  logic ss_fall;
  logic ss_rise;
  logic sck_rise;
  logic sck_fall;

  logic [cnt_w-1:0]            bit_cnt;
  logic [pmu_pkg::frame_w-1:0] tx_shift;
  logic [pmu_pkg::frame_w-1:0] rx_shift;

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      ss_q   <= 3'b111;  // deselected
      sck_q  <= 3'b000;
      mosi_q <= 2'b00;
    end else begin
      ss_q   <= {ss_q[1:0], ss};
      sck_q  <= {sck_q[1:0], sck};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign ss_active = ~ss_q[1];
  assign ss_fall   = ss_q[2] & ~ss_q[1];
  assign ss_rise   = ~ss_q[2] & ss_q[1];
  assign sck_rise  = ss_active & ~sck_q[2] & sck_q[1];
  assign sck_fall  = ss_active & sck_q[2] & ~sck_q[1];

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      bit_cnt         <= '0;
      tx_shift        <= '0;
      frame.frame_stb <= 1'b0;
    end else begin
      frame.frame_stb <= ss_rise && (bit_cnt == cnt_full);  // short or long frames are dropped
      if (ss_fall) begin
        bit_cnt  <= '0;
        tx_shift <= {frame.cmd_valid, {pad_w{1'b0}}, frame.cmd_word};
      end else begin
        if (sck_rise && (bit_cnt != '1)) begin
          bit_cnt <= bit_cnt + 1'b1;  // saturates so overlong frames never match
        end
        if (sck_fall) begin
          tx_shift <= {tx_shift[pmu_pkg::frame_w-2:0], 1'b0};
        end
      end
    end
  end

  // mosi lines up with the synced sck, both went through two flops
  always_ff @(posedge s_axi_aclk) begin
    if (sck_rise) begin
      rx_shift <= {rx_shift[pmu_pkg::frame_w-2:0], mosi_q[1]};
    end
  end

  assign frame.rx_frame = rx_shift;
  assign miso           = tx_shift[pmu_pkg::frame_w-1];

endmodule

`default_nettype wire

//--- rtl/pmu_status_store.sv
/* pmu status store
   latches received frames by type, decodes them and raises the interrupt */
`timescale 1ns/1ps
`default_nettype none

module pmu_status_store (
  input  logic                 s_axi_aclk,
  input  logic                 s_axi_areset,
  pmu_frame_if.rx_sink         frame,
  input  logic [7:0]           irq_enable,
  output pmu_pkg::pmu_status_t status,
  output logic                 irq
);

  logic [pmu_pkg::frame_w-1:0] frame_bat;
  logic [pmu_pkg::frame_w-1:0] frame_gauge;
  logic [pmu_pkg::frame_w-1:0] frame_charge;

  logic       load_bat;
  logic       load_gauge;
  logic       load_charge;
  logic [7:0] gauge_next;

  assign load_bat    = frame.frame_stb && (frame.rx_frame[7:0] == pmu_pkg::type_battery);
  assign load_gauge  = frame.frame_stb && (frame.rx_frame[7:0] == pmu_pkg::type_gauge);
  assign load_charge = frame.frame_stb && (frame.rx_frame[7:0] == pmu_pkg::type_charge);

  // irq follows the same clock as the frame registers
  assign gauge_next = load_gauge ? frame.rx_frame[63:56] : frame_gauge[63:56];

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      frame_bat    <= '0;
      frame_gauge  <= '0;
      frame_charge <= '0;
      irq          <= 1'b0;
    end else begin
      if (load_bat)    frame_bat    <= frame.rx_frame;
      if (load_gauge)  frame_gauge  <= frame.rx_frame;
      if (load_charge) frame_charge <= frame.rx_frame;
      irq <= |(gauge_next & irq_enable);
    end
  end

  always_comb begin
    status.battery_voltage     = {frame_bat[55:48], frame_bat[63:56]};
    status.battery_temp_alert  = frame_bat[47:46];
    status.battery_online      = frame_bat[45];
    status.battery_health      = frame_bat[44:42];
    status.battery_status      = frame_bat[41:40];
    status.charger_health      = frame_bat[37:36];
    status.charger_online      = frame_bat[35];
    status.charger_charge_type = frame_bat[33:32];
    status.version_maj         = frame_bat[15:12];
    status.version_min         = frame_bat[11:8];
    status.gauge_status        = frame_gauge[63:56];
    status.voltage             = {frame_gauge[47:40], frame_gauge[55:48]};
    status.temp                = {frame_gauge[31:24], frame_gauge[39:32]};
    status.charge_acc          = {frame_gauge[15:8], frame_gauge[23:16]};
    status.charge_last_full    = {frame_charge[15:8], frame_charge[23:16]};
    status.settings            = frame_charge[31:24];
  end

endmodule

`default_nettype wire

//--- verification/axi_pmu_assert.sv
/* axi pmu bound checks
   response exclusivity, read response hold and dropped pushes on a full fifo */
`timescale 1ns/1ps
`default_nettype none

module axi_pmu_assert #(
  parameter int PTR_W = 1
) (
  input logic             clk,
  input logic             rst,
  input logic             rvalid,
  input logic             rready,
  input logic             bvalid,
  input logic             push,
  input logic             full,
  input logic [PTR_W-1:0] wr_ptr,
  input logic [PTR_W-1:0] rd_ptr,
  input logic [PTR_W:0]   count
);

  localparam int depth = 1 << PTR_W;

  a_one_response: assert property (@(posedge clk) disable iff (rst) !(rvalid && bvalid))
    else $error("rvalid and bvalid high in the same cycle");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // pointers and count must still agree after a push that found the fifo full
  a_full_drop: assert property (@(posedge clk) disable iff (rst)
    push && full |=> (count <= (PTR_W + 1)'(depth))
                     && (PTR_W'(count) == PTR_W'(wr_ptr - rd_ptr)))
    else $error("push into a full fifo was not dropped");

endmodule

bind pmu_axi_regs axi_pmu_assert u_regs_assert (
  .clk    (s_axi_aclk),
  .rst    (s_axi_areset),
  .rvalid (s_axi_rvalid),
  .rready (s_axi_rready),
  .bvalid (s_axi_bvalid),
  .push   (1'b0),
  .full   (1'b0),
  .wr_ptr (1'b0),
  .rd_ptr (1'b0),
  .count  (2'b00)
);

bind pmu_cmd_fifo axi_pmu_assert #(.PTR_W(ptr_w)) u_fifo_assert (
  .clk    (s_axi_aclk),
  .rst    (s_axi_areset),
  .rvalid (1'b0),
  .rready (1'b0),
  .bvalid (1'b0),
  .push   (push),
  .full   (full),
  .wr_ptr (wr_ptr),
  .rd_ptr (rd_ptr),
  .count  (count)
);

`default_nettype wire

//--- verification/tb_axi_pmu.sv
/* axi pmu bridge testbench
   host register traffic and spi frames applied from a table of cases */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_pmu;

  localparam int clk_half   = 10;
  localparam int wait_limit = 200;  // clocks allowed for any handshake
  localparam int num_tests  = 14;

  typedef struct packed {
    logic        wr;        // host write before the frame
    logic [7:0]  waddr;
    logic [31:0] wdata;
    logic        frm;       // send a frame
    logic [7:0]  ftype;
    logic [63:0] miso;      // word expected back on miso
    logic [7:0]  rd_first;
    logic [7:0]  rd_last;
    logic [3:0]  hold;      // clocks of rready/bready back-pressure
  } test_t;

  logic        s_axi_aclk;
  logic        s_axi_areset;
  logic        ss;
  logic        mosi;
  logic        sck;
  logic        miso;
  logic [31:0] s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  logic [1:0]  s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  logic [31:0] s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0]  s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  logic        s_axi_irq;

  test_t       tests [num_tests];
  logic [31:0] rng;
  logic [63:0] m_bat;       // model of the latched frames
  logic [63:0] m_gauge;
  logic [63:0] m_charge;
  logic [31:0] m_shutdown;
  logic [7:0]  m_irq_en;
  int          errors;
  int          test_errors;
  int          tests_failed;

  axi_pmu #(
    .FIFO_DEPTH (16)
  ) u_axi_pmu (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_areset  (s_axi_areset),
    .ss            (ss),
    .mosi          (mosi),
    .sck           (sck),
    .miso          (miso),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_irq     (s_axi_irq)
  );

  initial begin
    s_axi_aclk = 1'b0;
    forever #clk_half s_axi_aclk = ~s_axi_aclk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // frames carry 16-bit values with the high byte at the lower position
  function automatic logic [15:0] swap16(input logic [63:0] f, input int k);
    return {f[8*k +: 8], f[8*k+8 +: 8]};
  endfunction

  function automatic logic [31:0] expected_reg(input logic [7:0] a);
    logic [31:0] v;
    v = 32'h0;
    case (a)
      pmu_pkg::reg_shutdown:    v = m_shutdown;
      pmu_pkg::reg_irq_ver:     v[15:0] = {m_irq_en, m_bat[15:8]};
      pmu_pkg::reg_battery:     v[23:0] = {swap16(m_bat, 6), m_bat[47:40]};
      pmu_pkg::reg_charger:     v[4:0] = {m_bat[33:32], m_bat[35], m_bat[37:36]};
      pmu_pkg::reg_gauge_a:     v = {swap16(m_gauge, 3), swap16(m_gauge, 1)};
      pmu_pkg::reg_gauge_b:     v[23:0] = {m_gauge[63:56], swap16(m_gauge, 5)};
      pmu_pkg::reg_charge_full: v[15:0] = swap16(m_charge, 1);
      pmu_pkg::reg_settings:    v[7:0] = m_charge[31:24];
      default:                  v = pmu_pkg::read_default;
    endcase
    return v;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s not seen within %0d clocks", what, wait_limit);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold);
    int n;
    @(posedge s_axi_aclk);
    s_axi_awaddr  <= {24'h0, addr};
    s_axi_awvalid <= 1'b1;
    s_axi_bready  <= 1'b0;
    n = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_awready) begin
      if (n == wait_limit) abort_on_timeout("awready");
      @(negedge s_axi_aclk);
      n++;
    end
    @(posedge s_axi_aclk);  // aw handshake
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= data;
    s_axi_wvalid  <= 1'b1;
    n = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_wready) begin
      if (n == wait_limit) abort_on_timeout("wready");
      @(negedge s_axi_aclk);
      n++;
    end
    @(posedge s_axi_aclk);  // w handshake
    s_axi_wvalid <= 1'b0;
    n = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_bvalid) begin
      if (n == wait_limit) abort_on_timeout("bvalid");
      @(negedge s_axi_aclk);
      n++;
    end
    check(64'(s_axi_bresp), 64'd0, "bresp not okay");
    repeat (hold) begin
      @(negedge s_axi_aclk);
      check(64'(s_axi_bvalid), 64'd1, "bvalid held under back-pressure");
      check(64'(s_axi_arready), 64'd0, "arready during write response");
      check(64'(s_axi_awready), 64'd0, "awready during write response");
    end
    @(posedge s_axi_aclk);
    s_axi_bready <= 1'b1;
    @(posedge s_axi_aclk);  // b handshake
    s_axi_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
    int          n;
    logic [31:0] first;
    @(posedge s_axi_aclk);
    s_axi_araddr  <= {24'h0, addr};
    s_axi_arvalid <= 1'b1;
    s_axi_rready  <= 1'b0;
    n = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_arready) begin
      if (n == wait_limit) abort_on_timeout("arready");
      @(negedge s_axi_aclk);
      n++;
    end
    @(posedge s_axi_aclk);  // ar handshake
    s_axi_arvalid <= 1'b0;
    n = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_rvalid) begin
      if (n == wait_limit) abort_on_timeout("rvalid");
      @(negedge s_axi_aclk);
      n++;
    end
    check(64'(s_axi_rresp), 64'd0, "rresp not okay");
    first = s_axi_rdata;
    repeat (hold) begin
      @(negedge s_axi_aclk);
      check(64'(s_axi_rvalid), 64'd1, "rvalid held under back-pressure");
      check(64'(s_axi_arready), 64'd0, "arready during read response");
      check(64'(s_axi_awready), 64'd0, "awready during read response");
    end
    data = s_axi_rdata;
    check(64'(data), 64'(first), "rdata changed while waiting");
    @(posedge s_axi_aclk);
    s_axi_rready <= 1'b1;
    @(posedge s_axi_aclk);  // r handshake
    s_axi_rready <= 1'b0;
  endtask

  // mode 0 master, 8 clocks per sck phase, miso taken just before each rise
  task automatic spi_frame(input logic [63:0] word, output logic [63:0] got);
    got = '0;
    @(posedge s_axi_aclk);
    ss  <= 1'b0;
    sck <= 1'b0;
    repeat (8) @(posedge s_axi_aclk);
    for (int i = 63; i >= 0; i--) begin
      mosi <= word[i];
      repeat (7) @(posedge s_axi_aclk);
      @(negedge s_axi_aclk);
      got[i] = miso;
      @(posedge s_axi_aclk);
      sck <= 1'b1;
      repeat (8) @(posedge s_axi_aclk);
      sck <= 1'b0;
    end
    repeat (8) @(posedge s_axi_aclk);
    ss   <= 1'b1;
    mosi <= 1'b0;
    repeat (6) @(posedge s_axi_aclk);  // strobe after 3 clocks, status 1 later
  endtask

  task automatic fill_table();
    // wr waddr wdata frm ftype miso rd_first rd_last hold
    tests[0]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd5, 64'h0, 8'h00, 8'h20, 4'd0};
    tests[1]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd0, 64'h0, 8'h00, 8'h1c, 4'd0};
    tests[2]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd1, 64'h0, 8'h00, 8'h1c, 4'd0};
    tests[3]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd2, 64'h0, 8'h00, 8'h1c, 4'd0};
    tests[4]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd5, 64'h0, 8'h00, 8'h1c, 4'd0};
    tests[5]  = '{1'b1, 8'h00, 32'h00a5_5a3c, 1'b1, 8'd0, 64'h8000_0000_a55a_3c00,
                  8'h00, 8'h08, 4'd0};
    tests[6]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd1, 64'h0, 8'h00, 8'h14, 4'd0};
    tests[7]  = '{1'b1, 8'h24, 32'h0000_1234, 1'b0, 8'd0, 64'h0, 8'h24, 8'h24, 4'd0};
    tests[8]  = '{1'b1, 8'h30, 32'h0000_beef, 1'b1, 8'd2, 64'h8000_0000_3412_2401,
                  8'h18, 8'h1c, 4'd0};
    tests[9]  = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd5, 64'h8000_0000_efbe_3001,
                  8'h00, 8'h04, 4'd0};
    tests[10] = '{1'b1, 8'h04, 32'h0000_ff00, 1'b1, 8'd1, 64'h0, 8'h04, 8'h14, 4'd0};
    tests[11] = '{1'b1, 8'h04, 32'h0, 1'b0, 8'd0, 64'h0, 8'h04, 8'h04, 4'd0};
    tests[12] = '{1'b1, 8'h00, 32'h0012_3456, 1'b0, 8'd0, 64'h0, 8'h00, 8'h00, 4'd6};
    tests[13] = '{1'b0, 8'h00, 32'h0, 1'b1, 8'd0, 64'h8000_0000_1234_5600,
                  8'h00, 8'h08, 4'd0};
  endtask

  task automatic run_test(input int t);
    test_t       c;
    logic [63:0] payload;
    logic [63:0] back;
    logic [31:0] rd;
    logic [7:0]  a;
    logic        irq_exp;
    int          n;
    c = tests[t];
    test_errors = 0;
    if (c.wr) begin
      axi_write(c.waddr, c.wdata, int'(c.hold));
      if (c.waddr == pmu_pkg::reg_shutdown) m_shutdown = c.wdata;
      if (c.waddr == pmu_pkg::reg_irq_ver) m_irq_en = c.wdata[15:8];
    end
    if (c.frm) begin
      rng = xorshift(rng);
      payload[63:32] = rng;
      rng = xorshift(rng);
      payload[31:0] = rng;
      payload[7:0] = c.ftype;  // type byte
      spi_frame(payload, back);
      check(back, c.miso, $sformatf("test %0d miso word", t));
      case (c.ftype)
        pmu_pkg::type_battery: m_bat = payload;
        pmu_pkg::type_gauge:   m_gauge = payload;
        pmu_pkg::type_charge:  m_charge = payload;
        default: ;
      endcase
    end
    a = c.rd_first;
    while (a <= c.rd_last) begin
      axi_read(a, int'(c.hold), rd);
      check(64'(rd), 64'(expected_reg(a)), $sformatf("test %0d read of %h", t, a));
      a = a + 8'd4;
    end
    irq_exp = |(m_gauge[63:56] & m_irq_en);
    n = 0;
    @(negedge s_axi_aclk);
    while (s_axi_irq !== irq_exp && n < 8) begin
      @(negedge s_axi_aclk);
      n++;
    end
    check(64'(s_axi_irq), 64'(irq_exp), $sformatf("test %0d irq", t));
    if (test_errors == 0) begin
      $display("test %0d: ok", t);
    end else begin
      $display("test %0d: %0d mismatches", t, test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    s_axi_areset  <= 1'b1;
    ss            <= 1'b1;
    sck           <= 1'b0;
    mosi          <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= 4'hf;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b0;
    s_axi_araddr  <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b0;
    rng = 32'h114a_7689;
    m_bat = '0;
    m_gauge = '0;
    m_charge = '0;
    m_shutdown = '0;
    m_irq_en = '0;
    errors = 0;
    tests_failed = 0;
    fill_table();
    repeat (8) @(posedge s_axi_aclk);
    s_axi_areset <= 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d failed, %0d mismatches", num_tests, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
